// ==== tb.f ====
+incdir+hdl
hdl/rf_pkg.sv
hdl/rf_write_decoder.sv
hdl/rf_write_merge.sv
hdl/rf_read_extract.sv
hdl/register_file.sv
verification/register_file_chk.sv
verification/tb_register_file.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the register file testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_register_file || exit 1

out=$(./obj_dir/Vtb_register_file)
echo "$out"

echo "$out" | grep -qx "Everything OK" && echo "Simulation passed" || {
    echo "Simulation failed"
    exit 1
}

// ==== verification/tb_register_file.sv ====
`timescale 1ns/10ps

`include "rf_config.svh"

module tb_register_file;

    localparam int CLK_PERIOD    = 100;
    localparam int RESET_CYCLES  = 8;
    localparam int RANDOM_CYCLES = 100;
    // Directed tests plus random run take about 200 cycles
    localparam int MAX_CYCLES    = 2000;

    logic              clk;
    logic              rst_n;
    rf_pkg::reg_idx_t  sr1;
    rf_pkg::reg_idx_t  sr2;
    rf_pkg::reg_idx_t  sr3;
    rf_pkg::reg_idx_t  sr4;
    rf_pkg::reg_idx_t  dr1;
    rf_pkg::reg_idx_t  dr2;
    rf_pkg::reg_idx_t  dr3;
    logic              write_dr1;
    logic              write_dr2;
    logic              write_dr3;
    rf_pkg::word_t     result1;
    rf_pkg::word_t     result2;
    rf_pkg::word_t     result3;
    rf_pkg::size_t     write_size;
    rf_pkg::size_t     read_size;
    rf_pkg::word_t     rega;
    rf_pkg::word_t     regb;
    rf_pkg::word_t     regc;
    rf_pkg::word_t     regd;

    rf_pkg::word_t     model [`RF_NUM_REGS];
    int                errors = 0;
    int                checks = 0;
    int                cycle_count = 0;
    integer            seed = 32'h9073_945b;

    register_file u_register_file (
        .clk        (clk),
        .rst_n      (rst_n),
        .sr1        (sr1),
        .sr2        (sr2),
        .sr3        (sr3),
        .sr4        (sr4),
        .dr1        (dr1),
        .dr2        (dr2),
        .dr3        (dr3),
        .write_dr1  (write_dr1),
        .write_dr2  (write_dr2),
        .write_dr3  (write_dr3),
        .result1    (result1),
        .result2    (result2),
        .result3    (result3),
        .write_size (write_size),
        .read_size  (read_size),
        .rega       (rega),
        .regb       (regb),
        .regc       (regc),
        .regd       (regd)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: tests did not finish within %0d clock cycles", MAX_CYCLES);
            $display("Something failed");
            $finish;
        end
    end

    // x86 read view of the model, byte reads of 4..7 give AH, CH, DH, BH
    function automatic rf_pkg::word_t model_read(input rf_pkg::reg_idx_t sr,
                                                 input rf_pkg::size_t size);
        rf_pkg::word_t value;
        value = '0;
        case (size)
            2'd0: begin
                if (sr >= 3'd4) begin
                    value[7:0] = model[sr - 3'd4][15:8];
                end else begin
                    value[7:0] = model[sr][7:0];
                end
            end
            2'd1: value[15:0] = model[sr][15:0];
            2'd2: value = model[sr];
            default: value = '0;
        endcase
        return value;
    endfunction

    task automatic model_write(input rf_pkg::reg_idx_t dr, input logic we,
                               input rf_pkg::word_t result, input rf_pkg::size_t size);
        if (we) begin
            case (size)
                2'd0: begin
                    if (dr >= 3'd4) begin
                        model[dr - 3'd4][15:8] = result[7:0];
                    end else begin
                        model[dr][7:0] = result[7:0];
                    end
                end
                2'd1: model[dr][15:0] = result[15:0];
                2'd2: model[dr] = result;
                default: ;
            endcase
        end
    endtask

    // Later writes win, so port 1 goes last
    task automatic update_model();
        if (!rst_n) begin
            for (int r = 0; r < `RF_NUM_REGS; r++) begin
                model[r] = '0;
            end
        end else begin
            model_write(dr3, write_dr3, result3, write_size);
            model_write(dr2, write_dr2, result2, write_size);
            model_write(dr1, write_dr1, result1, write_size);
        end
    endtask

    task automatic check_value(input string name, input rf_pkg::word_t expected,
                               input rf_pkg::word_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED at time %0t: %s expected %h, actual %h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic next_cycle();
        @(negedge clk);
        write_dr1 = 1'b0;
        write_dr2 = 1'b0;
        write_dr3 = 1'b0;
    endtask

    // Reads are sampled mid low phase, then the model takes the edge's writes
    task automatic end_cycle();
        #(CLK_PERIOD/4);
        check_value("rega", model_read(sr1, read_size), rega);
        check_value("regb", model_read(sr2, read_size), regb);
        check_value("regc", model_read(sr3, read_size), regc);
        check_value("regd", model_read(sr4, read_size), regd);
        @(posedge clk);
        update_model();
    endtask

    task automatic drive_write(input int port, input rf_pkg::reg_idx_t dr,
                               input rf_pkg::word_t result);
        case (port)
            1: begin
                dr1 = dr;
                write_dr1 = 1'b1;
                result1 = result;
            end
            2: begin
                dr2 = dr;
                write_dr2 = 1'b1;
                result2 = result;
            end
            default: begin
                dr3 = dr;
                write_dr3 = 1'b1;
                result3 = result;
            end
        endcase
    endtask

    task automatic set_reads(input rf_pkg::reg_idx_t base, input rf_pkg::size_t size);
        sr1 = base;
        sr2 = base + 3'd1;
        sr3 = base + 3'd2;
        sr4 = base + 3'd3;
        read_size = size;
    endtask

    task automatic read_regs(input rf_pkg::reg_idx_t base, input rf_pkg::size_t size);
        next_cycle();
        set_reads(base, size);
        end_cycle();
    endtask

    task automatic test_reset_reads();
        for (int sz = 0; sz < 4; sz++) begin
            read_regs(3'd0, rf_pkg::size_t'(sz));
            read_regs(3'd4, rf_pkg::size_t'(sz));
        end
    endtask

    task automatic test_dword_ports();
        for (int p = 1; p <= 3; p++) begin
            next_cycle();
            write_size = rf_pkg::SIZE_DWORD;
            drive_write(p, rf_pkg::reg_idx_t'(p), $random(seed));
            sr1 = rf_pkg::reg_idx_t'(p);
            sr2 = rf_pkg::reg_idx_t'(p);
            sr3 = rf_pkg::reg_idx_t'(p);
            sr4 = rf_pkg::reg_idx_t'(p);
            read_size = rf_pkg::SIZE_DWORD;
            end_cycle();
            // Same reads again, now after the edge
            next_cycle();
            end_cycle();
        end
    endtask

    task automatic test_partial_writes();
        next_cycle();
        write_size = rf_pkg::SIZE_DWORD;
        drive_write(1, 3'd0, 32'h1122_3344);
        drive_write(2, 3'd1, 32'h5566_7788);
        drive_write(3, 3'd2, 32'h99aa_bbcc);
        end_cycle();
        next_cycle();
        drive_write(1, 3'd3, 32'hddee_ff00);
        end_cycle();
        // AH, CH, DH, BH
        for (int r = 4; r < 8; r++) begin
            next_cycle();
            write_size = rf_pkg::SIZE_BYTE;
            drive_write(1, rf_pkg::reg_idx_t'(r), $random(seed));
            set_reads(3'd0, rf_pkg::SIZE_DWORD);
            end_cycle();
        end
        read_regs(3'd0, rf_pkg::SIZE_DWORD);
        read_regs(3'd4, rf_pkg::SIZE_BYTE);
        read_regs(3'd0, rf_pkg::SIZE_BYTE);
        for (int r = 0; r < 4; r++) begin
            next_cycle();
            write_size = rf_pkg::SIZE_BYTE;
            drive_write(2, rf_pkg::reg_idx_t'(r), $random(seed));
            end_cycle();
        end
        read_regs(3'd0, rf_pkg::SIZE_DWORD);
        read_regs(3'd0, rf_pkg::SIZE_BYTE);
        for (int r = 0; r < 8; r++) begin
            next_cycle();
            write_size = rf_pkg::SIZE_WORD;
            drive_write(3, rf_pkg::reg_idx_t'(r), $random(seed));
            end_cycle();
        end
        read_regs(3'd0, rf_pkg::SIZE_DWORD);
        read_regs(3'd4, rf_pkg::SIZE_DWORD);
        read_regs(3'd0, rf_pkg::SIZE_WORD);
        read_regs(3'd4, rf_pkg::SIZE_WORD);
        read_regs(3'd4, rf_pkg::SIZE_BYTE);
    endtask

    task automatic test_simultaneous();
        next_cycle();
        write_size = rf_pkg::SIZE_DWORD;
        drive_write(1, 3'd5, $random(seed));
        drive_write(2, 3'd6, $random(seed));
        drive_write(3, 3'd7, $random(seed));
        end_cycle();
        read_regs(3'd4, rf_pkg::SIZE_DWORD);
        // All three ports on EDX
        next_cycle();
        drive_write(1, 3'd2, $random(seed));
        drive_write(2, 3'd2, $random(seed));
        drive_write(3, 3'd2, $random(seed));
        end_cycle();
        read_regs(3'd0, rf_pkg::SIZE_DWORD);
        // AL from ports 1 and 3, AH from port 2
        next_cycle();
        write_size = rf_pkg::SIZE_BYTE;
        drive_write(1, 3'd0, $random(seed));
        drive_write(2, 3'd4, $random(seed));
        drive_write(3, 3'd0, $random(seed));
        end_cycle();
        read_regs(3'd0, rf_pkg::SIZE_DWORD);
        next_cycle();
        write_size = rf_pkg::SIZE_BYTE;
        drive_write(1, 3'd1, $random(seed));
        drive_write(2, 3'd5, $random(seed));
        drive_write(3, 3'd5, $random(seed));
        end_cycle();
        read_regs(3'd0, rf_pkg::SIZE_DWORD);
        next_cycle();
        write_size = rf_pkg::SIZE_WORD;
        drive_write(1, 3'd4, $random(seed));
        drive_write(2, 3'd3, $random(seed));
        drive_write(3, 3'd3, $random(seed));
        end_cycle();
        read_regs(3'd0, rf_pkg::SIZE_DWORD);
        read_regs(3'd4, rf_pkg::SIZE_DWORD);
    endtask

    task automatic test_reserved_size();
        next_cycle();
        write_size = 2'd3;
        drive_write(1, 3'd0, $random(seed));
        drive_write(2, 3'd4, $random(seed));
        drive_write(3, 3'd7, $random(seed));
        set_reads(3'd0, rf_pkg::SIZE_DWORD);
        end_cycle();
        read_regs(3'd0, rf_pkg::SIZE_DWORD);
        read_regs(3'd4, rf_pkg::SIZE_DWORD);
        read_regs(3'd0, 2'd3);
        read_regs(3'd4, 2'd3);
    endtask

    task automatic test_random();
        logic [31:0] rnd;
        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            next_cycle();
            rnd = $random(seed);
            // Mostly legal write sizes, code 3 becomes dword
            write_size = (rnd[1:0] == 2'd3) ? rf_pkg::SIZE_DWORD : rnd[1:0];
            read_size = rnd[3:2];
            write_dr1 = rnd[4];
            write_dr2 = rnd[5];
            write_dr3 = rnd[6];
            dr1 = rnd[9:7];
            dr2 = rnd[12:10];
            dr3 = rnd[15:13];
            sr1 = rnd[18:16];
            sr2 = rnd[21:19];
            sr3 = rnd[24:22];
            sr4 = rnd[27:25];
            result1 = $random(seed);
            result2 = $random(seed);
            result3 = $random(seed);
            end_cycle();
        end
    endtask

    initial begin
        rst_n = 1'b0;
        sr1 = '0;
        sr2 = '0;
        sr3 = '0;
        sr4 = '0;
        dr1 = '0;
        dr2 = '0;
        dr3 = '0;
        write_dr1 = 1'b0;
        write_dr2 = 1'b0;
        write_dr3 = 1'b0;
        result1 = '0;
        result2 = '0;
        result3 = '0;
        write_size = '0;
        read_size = '0;
        for (int r = 0; r < `RF_NUM_REGS; r++) begin
            model[r] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        test_reset_reads();
        test_dword_ports();
        test_partial_writes();
        test_simultaneous();
        test_reserved_size();
        test_random();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== verification/register_file_chk.sv ====
`timescale 1ns/10ps

`include "rf_config.svh"

module register_file_chk (
    input logic              clk,
    input logic              rst_n,
    input rf_pkg::word_t     regs      [`RF_NUM_REGS],
    input rf_pkg::lane_map_t lane_we,
    input rf_pkg::word_t     next_data [`RF_NUM_REGS]
);

    for (genvar r = 0; r < `RF_NUM_REGS; r++) begin : g_reg

        a_reset_clears: assert property (@(posedge clk)
            !rst_n |=> regs[r] == '0)
            else $error("register %0d not cleared by reset", r);

        // No lane enabled, so the whole register holds
        a_idle_holds: assert property (@(posedge clk)
            rst_n && (lane_we[r*`RF_LANES +: `RF_LANES] == '0) |=> regs[r] == $past(regs[r]))
            else $error("register %0d changed without a lane enable", r);

        for (genvar l = 0; l < `RF_LANES; l++) begin : g_lane
            a_lane_loaded: assert property (@(posedge clk)
                rst_n && lane_we[r*`RF_LANES + l]
                |=> regs[r][8*l +: 8] == $past(next_data[r][8*l +: 8]))
                else $error("register %0d lane %0d did not load the merged byte", r, l);
        end
    end

endmodule

bind register_file register_file_chk u_chk (
    .clk       (clk),
    .rst_n     (rst_n),
    .regs      (regs),
    .lane_we   (lane_we),
    .next_data (next_data)
);

// ==== hdl/register_file.sv ====
`timescale 1ns/10ps

`include "rf_config.svh"

module register_file (
    input  logic             clk,
    input  logic             rst_n,
    input  rf_pkg::reg_idx_t sr1,
    input  rf_pkg::reg_idx_t sr2,
    input  rf_pkg::reg_idx_t sr3,
    input  rf_pkg::reg_idx_t sr4,
    input  rf_pkg::reg_idx_t dr1,
    input  rf_pkg::reg_idx_t dr2,
    input  rf_pkg::reg_idx_t dr3,
    input  logic             write_dr1,
    input  logic             write_dr2,
    input  logic             write_dr3,
    input  rf_pkg::word_t    result1,
    input  rf_pkg::word_t    result2,
    input  rf_pkg::word_t    result3,
    input  rf_pkg::size_t    write_size,
    input  rf_pkg::size_t    read_size,
    output rf_pkg::word_t    rega,
    output rf_pkg::word_t    regb,
    output rf_pkg::word_t    regc,
    output rf_pkg::word_t    regd
);

    rf_pkg::lane_map_t lane_en1;
    rf_pkg::lane_map_t lane_en2;
    rf_pkg::lane_map_t lane_en3;
    logic              high_byte1;
    logic              high_byte2;
    logic              high_byte3;
    rf_pkg::lane_map_t lane_we;
    rf_pkg::word_t     next_data [`RF_NUM_REGS];
    rf_pkg::word_t     regs      [`RF_NUM_REGS];

    // One decoder per write port
    rf_write_decoder u_dec1 (
        .dr         (dr1),
        .write_dr   (write_dr1),
        .write_size (write_size),
        .lane_en    (lane_en1),
        .high_byte  (high_byte1)
    );

    rf_write_decoder u_dec2 (
        .dr         (dr2),
        .write_dr   (write_dr2),
        .write_size (write_size),
        .lane_en    (lane_en2),
        .high_byte  (high_byte2)
    );

    rf_write_decoder u_dec3 (
        .dr         (dr3),
        .write_dr   (write_dr3),
        .write_size (write_size),
        .lane_en    (lane_en3),
        .high_byte  (high_byte3)
    );

    rf_write_merge u_merge (
        .lane_en1   (lane_en1),
        .lane_en2   (lane_en2),
        .lane_en3   (lane_en3),
        .high_byte1 (high_byte1),
        .high_byte2 (high_byte2),
        .high_byte3 (high_byte3),
        .result1    (result1),
        .result2    (result2),
        .result3    (result3),
        .lane_we    (lane_we),
        .next_data  (next_data)
    );

    // Storage with byte-lane enables
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int r = 0; r < `RF_NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int r = 0; r < `RF_NUM_REGS; r++) begin
                for (int l = 0; l < `RF_LANES; l++) begin
                    if (lane_we[r*`RF_LANES + l]) begin
                        regs[r][8*l +: 8] <= next_data[r][8*l +: 8];
                    end
                end
            end
        end
    end

    // Combinational read ports
    rf_read_extract u_rd_a (
        .regs      (regs),
        .sr        (sr1),
        .read_size (read_size),
        .rdata     (rega)
    );

    rf_read_extract u_rd_b (
        .regs      (regs),
        .sr        (sr2),
        .read_size (read_size),
        .rdata     (regb)
    );

    rf_read_extract u_rd_c (
        .regs      (regs),
        .sr        (sr3),
        .read_size (read_size),
        .rdata     (regc)
    );

    rf_read_extract u_rd_d (
        .regs      (regs),
        .sr        (sr4),
        .read_size (read_size),
        .rdata     (regd)
    );

endmodule

// ==== hdl/rf_read_extract.sv ====
`timescale 1ns/10ps

`include "rf_config.svh"

module rf_read_extract (
    input  rf_pkg::word_t    regs [`RF_NUM_REGS],
    input  rf_pkg::reg_idx_t sr,
    input  rf_pkg::size_t    read_size,
    output rf_pkg::word_t    rdata
);

    localparam int IDX_MSB = $bits(rf_pkg::reg_idx_t) - 1;

    rf_pkg::reg_idx_t byte_reg;

    // Byte reads of 4..7 map onto the low four registers
    assign byte_reg = {1'b0, sr[IDX_MSB-1:0]};

    always_comb begin
        rdata = '0;
        case (read_size)
            rf_pkg::SIZE_BYTE: begin
                if (sr[IDX_MSB]) begin
                    rdata[7:0] = regs[byte_reg][15:8];
                end else begin
                    rdata[7:0] = regs[sr][7:0];
                end
            end
            rf_pkg::SIZE_WORD: begin
                rdata[15:0] = regs[sr][15:0];
            end
            rf_pkg::SIZE_DWORD: begin
                rdata = regs[sr];
            end
            default: begin
                rdata = '0;
            end
        endcase
    end

endmodule

// ==== hdl/rf_write_merge.sv ====
`timescale 1ns/10ps

`include "rf_config.svh"

module rf_write_merge (
    input  rf_pkg::lane_map_t lane_en1,
    input  rf_pkg::lane_map_t lane_en2,
    input  rf_pkg::lane_map_t lane_en3,
    input  logic              high_byte1,
    input  logic              high_byte2,
    input  logic              high_byte3,
    input  rf_pkg::word_t     result1,
    input  rf_pkg::word_t     result2,
    input  rf_pkg::word_t     result3,
    output rf_pkg::lane_map_t lane_we,
    output rf_pkg::word_t     next_data [`RF_NUM_REGS]
);

    rf_pkg::word_t aligned1;
    rf_pkg::word_t aligned2;
    rf_pkg::word_t aligned3;

    // High-byte writes carry their byte in result bits 7:0
    function automatic rf_pkg::word_t align(input rf_pkg::word_t result, input logic high_byte);
        rf_pkg::word_t data;
        data = result;
        if (high_byte) begin
            data[15:8] = result[7:0];
        end
        return data;
    endfunction

    assign aligned1 = align(result1, high_byte1);
    assign aligned2 = align(result2, high_byte2);
    assign aligned3 = align(result3, high_byte3);

    assign lane_we = lane_en1 | lane_en2 | lane_en3;

    // Fixed priority per lane, port 1 first
    always_comb begin
        for (int r = 0; r < `RF_NUM_REGS; r++) begin
            for (int l = 0; l < `RF_LANES; l++) begin
                if (lane_en1[r*`RF_LANES + l]) begin
                    next_data[r][8*l +: 8] = aligned1[8*l +: 8];
                end else if (lane_en2[r*`RF_LANES + l]) begin
                    next_data[r][8*l +: 8] = aligned2[8*l +: 8];
                end else begin
                    // Port 3 or an unused lane
                    next_data[r][8*l +: 8] = aligned3[8*l +: 8];
                end
            end
        end
    end

endmodule

// ==== hdl/rf_write_decoder.sv ====
`timescale 1ns/10ps

`include "rf_config.svh"

module rf_write_decoder (
    input  rf_pkg::reg_idx_t  dr,
    input  logic              write_dr,
    input  rf_pkg::size_t     write_size,
    output rf_pkg::lane_map_t lane_en,
    output logic              high_byte
);

    localparam int IDX_MSB = $bits(rf_pkg::reg_idx_t) - 1;

    logic [`RF_LANES-1:0] lanes;
    rf_pkg::reg_idx_t     target;

    always_comb begin
        lanes     = '0;
        target    = dr;
        high_byte = 1'b0;

        case (write_size)
            rf_pkg::SIZE_BYTE: begin
                // AH, CH, DH, BH live in bits 15:8 of the low four registers
                if (dr[IDX_MSB]) begin
                    target    = {1'b0, dr[IDX_MSB-1:0]};
                    lanes[1]  = 1'b1;
                    high_byte = 1'b1;
                end else begin
                    lanes[0] = 1'b1;
                end
            end
            rf_pkg::SIZE_WORD: begin
                lanes[1:0] = 2'b11;
            end
            rf_pkg::SIZE_DWORD: begin
                lanes = '1;
            end
            default: begin
                lanes = '0;
            end
        endcase

        if (!write_dr) begin
            lanes     = '0;
            high_byte = 1'b0;
        end

        lane_en = '0;
        lane_en[target*`RF_LANES +: `RF_LANES] = lanes;
    end

endmodule

// ==== hdl/rf_pkg.sv ====
`include "rf_config.svh"

package rf_pkg;

    // Register number as seen by the datapath
    typedef logic [$clog2(`RF_NUM_REGS)-1:0] reg_idx_t;

    // Register contents and execution results
    typedef logic [`RF_DATA_W-1:0] word_t;

    // Access size, code 3 is reserved
    typedef logic [1:0] size_t;

    // Bit 4*r+l is lane l of register r
    typedef logic [`RF_NUM_REGS*`RF_LANES-1:0] lane_map_t;

    localparam size_t SIZE_BYTE  = 2'd0;
    localparam size_t SIZE_WORD  = 2'd1;
    localparam size_t SIZE_DWORD = 2'd2;

endpackage

// ==== hdl/rf_config.svh ====
`ifndef RF_CONFIG_SVH
`define RF_CONFIG_SVH

// Architectural registers, EAX through EDI
`define RF_NUM_REGS 8

// Register and result width
`define RF_DATA_W 32

// Byte lanes per register
`define RF_LANES 4

`endif
